// ==== compile.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_issue.sv
hw/lsu_resp_queue.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
dv/lsu_tb_clk.sv
dv/lsu_sva.sv
dv/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the LSU testbench with Verilator and run it
# The run passes only if the log holds the pass line

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f compile.f --top-module lsu_tb -o lsu_sim \
    > build.log 2>&1 \
    && ./obj_dir/lsu_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^Finished with no errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// ==== dv/lsu_tb.sv ====
//----------------------------
// LSU testbench
// Random opcodes, memory responder,
// in-order reference model
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;

localparam int NUM_TESTS = 400;
localparam int MAX_CYCLES = NUM_TESTS * 20;

// Op codes: 0 LB, 1 LH, 2 LW, 3 LBU, 4 LHU, 5 SB, 6 SH, 7 SW
typedef struct packed
{
    logic [31:0] addr;
    logic [2:0]  op;
    logic [31:0] data;
    logic        misal;
} acc_t;

logic clk;
logic rst;
logic opcode_valid_i;
logic [31:0] opcode_opcode_i;
logic [31:0] opcode_ra_operand_i;
logic [31:0] opcode_rb_operand_i;
logic stall_o;
logic [31:0] mem_addr_o;
logic [31:0] mem_data_wr_o;
logic mem_rd_o;
logic [3:0] mem_wr_o;
logic mem_accept_i;
logic [31:0] mem_data_rd_i;
logic mem_ack_i;
logic mem_error_i;
logic writeback_valid_o;
logic [31:0] writeback_value_o;
logic [5:0] writeback_exception_o;

integer seed;
int errors;
int checks;
int n_taken;
int cycles;
logic taken_n;
acc_t cur;
acc_t stage_q[$];
acc_t flight_q[$];
logic [31:0] bus_mem[256];
logic [31:0] ref_mem[256];
logic [31:0] rsp_data_q[$];
logic rsp_err_q[$];
int rsp_wait_q[$];

lsu_tb_clk u_clk (.clk_o(clk), .rst_o(rst));

lsu_top u_dut
(
     .clk_i(clk), .rst_i(rst)
    ,.opcode_valid_i(opcode_valid_i), .opcode_opcode_i(opcode_opcode_i)
    ,.opcode_ra_operand_i(opcode_ra_operand_i), .opcode_rb_operand_i(opcode_rb_operand_i)
    ,.stall_o(stall_o), .mem_addr_o(mem_addr_o), .mem_data_wr_o(mem_data_wr_o)
    ,.mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o), .mem_accept_i(mem_accept_i)
    ,.mem_data_rd_i(mem_data_rd_i), .mem_ack_i(mem_ack_i), .mem_error_i(mem_error_i)
    ,.writeback_valid_o(writeback_valid_o), .writeback_value_o(writeback_value_o)
    ,.writeback_exception_o(writeback_exception_o)
);

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

function automatic logic [2:0] op_f3(input logic [2:0] op);
    case (op)
    3'd0, 3'd5: op_f3 = `LSU_F3_B;
    3'd1, 3'd6: op_f3 = `LSU_F3_H;
    3'd3:       op_f3 = `LSU_F3_BU;
    3'd4:       op_f3 = `LSU_F3_HU;
    default:    op_f3 = `LSU_F3_W;
    endcase
endfunction

// Lane strobe a store should drive
function automatic logic [3:0] store_strobe(input logic [2:0] op, input logic [31:0] a);
    case (op)
    3'd5:    store_strobe = 4'b0001 << a[1:0];
    3'd6:    store_strobe = a[1] ? 4'b1100 : 4'b0011;
    3'd7:    store_strobe = 4'b1111;
    default: store_strobe = 4'b0000;
    endcase
endfunction

// Selected lane, extended per op
function automatic logic [31:0] load_value(input logic [2:0] op, input logic [31:0] w,
                                           input logic [31:0] a);
    logic [7:0] b;
    logic [15:0] h;
    b = w[8*a[1:0] +: 8];
    h = a[1] ? w[31:16] : w[15:0];
    case (op)
    3'd0:    load_value = {{24{b[7]}}, b};
    3'd3:    load_value = {24'd0, b};
    3'd1:    load_value = {{16{h[15]}}, h};
    3'd4:    load_value = {16'd0, h};
    default: load_value = w;
    endcase
endfunction

//----------------------------
// Reference model
//----------------------------
task automatic check_writeback();
    acc_t e;
    logic is_load;
    logic [5:0] exp_exc;
    logic [31:0] exp_val;
    logic [7:0] idx;
    if (flight_q.size() != 0)
        e = flight_q.pop_front();
    else if (stage_q.size() != 0)
        e = stage_q.pop_front();
    else
    begin
        errors++;
        $display("Writeback at %0t with no access outstanding", $time);
        return;
    end
    is_load = (e.op < 3'd5);
    idx = e.addr[9:2];
    exp_val = e.addr;
    if (e.misal)
        exp_exc = is_load ? `LSU_EXC_MISALIGNED_LOAD : `LSU_EXC_MISALIGNED_STORE;
    else if (mem_error_i)
        exp_exc = is_load ? `LSU_EXC_FAULT_LOAD : `LSU_EXC_FAULT_STORE;
    else
    begin
        exp_exc = `LSU_EXC_NONE;
        exp_val = load_value(e.op, ref_mem[idx], e.addr);
        // Stores land in the model memory in completion order
        case (e.op)
        3'd5: ref_mem[idx][8*e.addr[1:0] +: 8] = e.data[7:0];
        3'd6: ref_mem[idx][16*e.addr[1] +: 16] = e.data[15:0];
        3'd7: ref_mem[idx] = e.data;
        default: ;
        endcase
    end
    check_value("writeback_exception_o", {26'd0, writeback_exception_o}, {26'd0, exp_exc});
    if (is_load || exp_exc != `LSU_EXC_NONE)
        check_value("writeback_value_o", writeback_value_o, exp_val);
endtask

// Request accepted by the responder
task automatic accept_request();
    acc_t e;
    logic [31:0] r;
    logic [7:0] idx;
    logic err;
    logic [3:0] strb;
    logic [31:0] mask;
    if (stage_q.size() == 0)
    begin
        errors++;
        $display("Memory request at %0t with no access waiting", $time);
        return;
    end
    e = stage_q.pop_front();
    if (e.misal)
    begin
        errors++;
        $display("Memory request at %0t for a misaligned access", $time);
    end
    strb = store_strobe(e.op, e.addr);
    check_value("mem_addr_o", mem_addr_o, {e.addr[31:2], 2'b00});
    check_value("mem_rd_o", {31'd0, mem_rd_o}, {31'd0, e.op < 3'd5});
    check_value("mem_wr_o", {28'd0, mem_wr_o}, {28'd0, strb});
    if (strb != 4'd0)
    begin
        for (int i = 0; i < 4; i++)
            mask[8*i +: 8] = {8{strb[i]}};
        // Store data shifted into the addressed lanes
        check_value("mem_data_wr_o", mem_data_wr_o & mask,
                    (e.data << (8 * e.addr[1:0])) & mask);
    end
    flight_q.push_back(e);
    r = $random(seed);
    // About one access in 16 faults
    err = (r[3:0] == 4'd0);
    idx = mem_addr_o[9:2];
    rsp_data_q.push_back(bus_mem[idx]);
    for (int i = 0; i < 4; i++)
        if (mem_wr_o[i] && !err)
            bus_mem[idx][8*i +: 8] = mem_data_wr_o[8*i +: 8];
    rsp_err_q.push_back(err);
    rsp_wait_q.push_back((r[5:4] == 2'd3) ? 0 : int'(r[5:4]));
endtask

// Sampled mid cycle, effects apply on the next edge
task automatic monitor_step();
    logic fault;
    fault = writeback_valid_o && (writeback_exception_o != `LSU_EXC_NONE);
    if (writeback_valid_o)
        check_writeback();
    if ((mem_rd_o || (mem_wr_o != 4'd0)) && mem_accept_i)
        accept_request();
    // Fault drops the stage and squashes the taken opcode
    if (fault)
        stage_q.delete();
    taken_n = opcode_valid_i && !stall_o;
    if (taken_n)
    begin
        n_taken++;
        if (!fault)
            stage_q.push_back(cur);
    end
endtask

task automatic new_opcode();
    logic [31:0] r;
    logic [31:0] a;
    logic [11:0] imm;
    logic [2:0] f3;
    r = $random(seed);
    if (n_taken >= NUM_TESTS || r[15:13] == 3'd0)
    begin
        opcode_valid_i = 1'b0;
        return;
    end
    cur.op = r[2:0];
    a = {22'd0, r[12:3]};
    // Mostly aligned, the rest keeps random low bits
    if (r[17:16] != 2'd0)
    begin
        if (cur.op == 3'd1 || cur.op == 3'd4 || cur.op == 3'd6)
            a[0] = 1'b0;
        else if (cur.op == 3'd2 || cur.op == 3'd7)
            a[1:0] = 2'b00;
    end
    imm = {{5{r[24]}}, r[24:18]};
    cur.addr = a;
    cur.data = $random(seed);
    cur.misal = ((cur.op == 3'd1 || cur.op == 3'd4 || cur.op == 3'd6) && a[0]) ||
                ((cur.op == 3'd2 || cur.op == 3'd7) && (a[1:0] != 2'b00));
    f3 = op_f3(cur.op);
    opcode_valid_i = 1'b1;
    opcode_ra_operand_i = a - {{20{imm[11]}}, imm};
    opcode_rb_operand_i = cur.data;
    if (cur.op < 3'd5)
        opcode_opcode_i = {imm, 5'd1, f3, 5'd2, `LSU_OPC_LOAD};
    else
        opcode_opcode_i = {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], `LSU_OPC_STORE};
endtask

//----------------------------
// Responder and driver
//----------------------------
task automatic drive_step();
    logic [31:0] r;
    r = $random(seed);
    mem_accept_i = (r[1:0] != 2'd0);
    if (rsp_data_q.size() != 0 && rsp_wait_q[0] == 0)
    begin
        mem_ack_i = 1'b1;
        mem_data_rd_i = rsp_data_q.pop_front();
        mem_error_i = rsp_err_q.pop_front();
        void'(rsp_wait_q.pop_front());
    end
    else
    begin
        mem_ack_i = 1'b0;
        mem_error_i = 1'b0;
        mem_data_rd_i = r;
        if (rsp_wait_q.size() != 0)
            rsp_wait_q[0] = rsp_wait_q[0] - 1;
    end
    // Held until taken, as a stalled core would
    if (!opcode_valid_i || taken_n)
        new_opcode();
endtask

always @(posedge clk)
begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
        $display("Timeout after %0d cycles with %0d opcodes taken", cycles, n_taken);
        $display("Finished with errors");
        $finish;
    end
end

initial
begin
    seed = 32'h1acf;
    errors = 0;
    checks = 0;
    n_taken = 0;
    cycles = 0;
    taken_n = 1'b0;
    cur = '0;
    opcode_valid_i = 1'b0;
    opcode_opcode_i = '0;
    opcode_ra_operand_i = '0;
    opcode_rb_operand_i = '0;
    mem_accept_i = 1'b0;
    mem_data_rd_i = '0;
    mem_ack_i = 1'b0;
    mem_error_i = 1'b0;
    // Fill pattern from the whole word index
    for (int i = 0; i < 256; i++)
    begin
        bus_mem[i] = (32'h9e3779b9 * (i + 1)) ^ {24'd0, i[7:0]};
        ref_mem[i] = bus_mem[i];
    end
    @(negedge rst);
    while (n_taken < NUM_TESTS || stage_q.size() != 0 || flight_q.size() != 0 ||
           rsp_data_q.size() != 0)
    begin
        @(negedge clk);
        monitor_step();
        @(posedge clk);
        #1;
        drive_step();
    end
    // No stray writebacks once drained
    repeat (5)
    begin
        @(negedge clk);
        if (writeback_valid_o)
        begin
            errors++;
            $display("Extra writeback at %0t after all accesses completed", $time);
        end
    end
    $display("Opcodes taken: %0d, checks: %0d, errors: %0d", n_taken, checks, errors);
    if (errors == 0)
        $display("Finished with no errors");
    else
        $display("Finished with errors");
    $finish;
end

endmodule

// ==== dv/lsu_sva.sv ====
//----------------------------
// Bound assertions on the LSU
// memory and writeback ports
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_sva
(
     input logic                   clk_i
    ,input logic                   rst_i
    ,input logic                   opcode_valid_i
    ,input logic                   unaligned_i
    ,input logic                   stall_i
    ,input logic                   mem_rd_i
    ,input logic [`LSU_STRB_W-1:0] mem_wr_i
    ,input logic [`LSU_XLEN-1:0]   mem_addr_i
    ,input logic                   mem_accept_i
    ,input logic                   mem_ack_i
    ,input logic                   writeback_valid_i
    ,input logic [`LSU_EXC_W-1:0]  writeback_exception_i
);

logic req_w;
logic fault_w;
logic misal_q;

assign req_w   = mem_rd_i || (mem_wr_i != '0);
assign fault_w = writeback_valid_i && (writeback_exception_i != '0);

// Taken misaligned access not yet reported, a fault drops it
always_ff @(posedge clk_i)
begin
    if (rst_i || fault_w)
        misal_q <= 1'b0;
    else if (opcode_valid_i && !stall_i && unaligned_i)
        misal_q <= 1'b1;
end

// Never read and write together
a_rd_wr: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mem_rd_i && (mem_wr_i != '0)))
    else $error("Memory request is both read and write");

// Request held unchanged until accepted
a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_w && !mem_accept_i) |=> (req_w && $stable({mem_rd_i, mem_wr_i, mem_addr_i})))
    else $error("Memory request changed before it was accepted");

// Writeback without a memory ack needs a taken misaligned access
a_wb: assert property (@(posedge clk_i) disable iff (rst_i)
    (writeback_valid_i && !mem_ack_i) |-> misal_q)
    else $error("Writeback without an acknowledge or a misaligned access");

// Quiet first cycle out of reset
a_rst: assert property (@(posedge clk_i)
    $past(rst_i) |-> !stall_i)
    else $error("Stall raised right after reset");

endmodule

bind lsu_top lsu_sva u_sva
(
     .clk_i                 (clk_i)
    ,.rst_i                 (rst_i)
    ,.opcode_valid_i        (opcode_valid_i)
    ,.unaligned_i           (dec_unaligned_w)
    ,.stall_i               (stall_o)
    ,.mem_rd_i              (mem_rd_o)
    ,.mem_wr_i              (mem_wr_o)
    ,.mem_addr_i            (mem_addr_o)
    ,.mem_accept_i          (mem_accept_i)
    ,.mem_ack_i             (mem_ack_i)
    ,.writeback_valid_i     (writeback_valid_o)
    ,.writeback_exception_i (writeback_exception_o)
);

// ==== dv/lsu_tb_clk.sv ====
//----------------------------
// Testbench clock and reset
//----------------------------
`timescale 1ns/1ps

module lsu_tb_clk
(
     output logic clk_o
    ,output logic rst_o
);

// 8 ns period
initial
begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
end

// Reset held for 4 cycles, released just after an edge
initial
begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 rst_o = 1'b0;
end

endmodule

// ==== hw/lsu_top.sv ====
//----------------------------
// Load/store unit top level
// Decode, issue, queue, align
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top
(
     input  logic                     clk_i
    ,input  logic                     rst_i
    // Core side
    ,input  logic                     opcode_valid_i
    ,input  logic [`LSU_XLEN-1:0]     opcode_opcode_i
    ,input  logic [`LSU_XLEN-1:0]     opcode_ra_operand_i
    ,input  logic [`LSU_XLEN-1:0]     opcode_rb_operand_i
    ,output logic                     stall_o
    // Memory side
    ,output logic [`LSU_XLEN-1:0]     mem_addr_o
    ,output logic [`LSU_XLEN-1:0]     mem_data_wr_o
    ,output logic                     mem_rd_o
    ,output logic [`LSU_STRB_W-1:0]   mem_wr_o
    ,input  logic                     mem_accept_i
    ,input  logic [`LSU_XLEN-1:0]     mem_data_rd_i
    ,input  logic                     mem_ack_i
    ,input  logic                     mem_error_i
    // Writeback
    ,output logic                     writeback_valid_o
    ,output logic [`LSU_XLEN-1:0]     writeback_value_o
    ,output logic [`LSU_EXC_W-1:0]    writeback_exception_o
);

//----------------------------
// Decode to issue
//----------------------------
logic [`LSU_XLEN-1:0]   dec_addr_w;
logic                   dec_load_w;
logic                   dec_signed_w;
lsu_pkg::lsu_size_e     dec_size_w;
logic                   dec_unaligned_w;
logic                   dec_rd_w;
logic [`LSU_STRB_W-1:0] dec_wr_w;
logic [`LSU_XLEN-1:0]   dec_wr_data_w;

// Issue to queue and align
logic                   push_w;
lsu_pkg::lsu_tag_t      push_tag_w;
logic                   dummy_ack_w;
lsu_pkg::lsu_tag_t      head_tag_w;

lsu_decode u_decode
(
     .opcode_valid_i      (opcode_valid_i)
    ,.opcode_opcode_i     (opcode_opcode_i)
    ,.opcode_ra_operand_i (opcode_ra_operand_i)
    ,.opcode_rb_operand_i (opcode_rb_operand_i)
    ,.addr_o              (dec_addr_w)
    ,.load_o              (dec_load_w)
    // Store flag implied by a nonzero strobe
    ,.store_o             ()
    ,.signed_o            (dec_signed_w)
    ,.size_o              (dec_size_w)
    ,.unaligned_o         (dec_unaligned_w)
    ,.rd_o                (dec_rd_w)
    ,.wr_o                (dec_wr_w)
    ,.wr_data_o           (dec_wr_data_w)
);

lsu_issue u_issue
(
     .clk_i         (clk_i)
    ,.rst_i         (rst_i)
    ,.addr_i        (dec_addr_w)
    ,.load_i        (dec_load_w)
    ,.signed_i      (dec_signed_w)
    ,.size_i        (dec_size_w)
    ,.unaligned_i   (dec_unaligned_w)
    ,.rd_i          (dec_rd_w)
    ,.wr_i          (dec_wr_w)
    ,.wr_data_i     (dec_wr_data_w)
    ,.mem_accept_i  (mem_accept_i)
    ,.mem_ack_i     (mem_ack_i)
    ,.mem_error_i   (mem_error_i)
    ,.mem_addr_o    (mem_addr_o)
    ,.mem_data_wr_o (mem_data_wr_o)
    ,.mem_rd_o      (mem_rd_o)
    ,.mem_wr_o      (mem_wr_o)
    ,.push_o        (push_w)
    ,.push_tag_o    (push_tag_w)
    ,.dummy_ack_o   (dummy_ack_w)
    ,.stall_o       (stall_o)
);

// Pops on a real or a dummy acknowledge
lsu_resp_queue #(.DEPTH(`LSU_QUEUE_DEPTH)) u_queue
(
     .clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.push_i     (push_w)
    ,.push_tag_i (push_tag_w)
    ,.pop_i      (mem_ack_i || dummy_ack_w)
    ,.head_tag_o (head_tag_w)
);

lsu_load_align u_align
(
     .mem_ack_i             (mem_ack_i)
    ,.mem_error_i           (mem_error_i)
    ,.mem_data_rd_i         (mem_data_rd_i)
    ,.dummy_ack_i           (dummy_ack_w)
    ,.head_tag_i            (head_tag_w)
    ,.writeback_valid_o     (writeback_valid_o)
    ,.writeback_value_o     (writeback_value_o)
    ,.writeback_exception_o (writeback_exception_o)
);

endmodule

// ==== hw/lsu_load_align.sv ====
//----------------------------
// Writeback formatting
// Load extraction, extension and
// exception coding
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_load_align
(
     input  logic                     mem_ack_i
    ,input  logic                     mem_error_i
    ,input  logic [`LSU_XLEN-1:0]     mem_data_rd_i
    ,input  logic                     dummy_ack_i
    ,input  lsu_pkg::lsu_tag_t        head_tag_i
    ,output logic                     writeback_valid_o
    ,output logic [`LSU_XLEN-1:0]     writeback_value_o
    ,output logic [`LSU_EXC_W-1:0]    writeback_exception_o
);

logic       bus_fault_w;
logic [7:0] byte_w;
logic [15:0] half_w;

assign bus_fault_w = mem_ack_i && mem_error_i;

//----------------------------
// Lane select
//----------------------------
always_comb
begin
    case (head_tag_i.addr[1:0])
    2'd3:    byte_w = mem_data_rd_i[31:24];
    2'd2:    byte_w = mem_data_rd_i[23:16];
    2'd1:    byte_w = mem_data_rd_i[15:8];
    default: byte_w = mem_data_rd_i[7:0];
    endcase
end

assign half_w = head_tag_i.addr[1] ? mem_data_rd_i[31:16] : mem_data_rd_i[15:0];

// Result or fault address
always_comb
begin
    writeback_value_o = '0;
    if (bus_fault_w || dummy_ack_i)
        writeback_value_o = head_tag_i.addr;
    else if (mem_ack_i && head_tag_i.load)
    begin
        case (head_tag_i.size)
        lsu_pkg::LSU_SIZE_B:
            writeback_value_o = {{24{head_tag_i.sign_ext && byte_w[7]}}, byte_w};
        lsu_pkg::LSU_SIZE_H:
            writeback_value_o = {{16{head_tag_i.sign_ext && half_w[15]}}, half_w};
        default:
            writeback_value_o = mem_data_rd_i;
        endcase
    end
end

assign writeback_valid_o = mem_ack_i || dummy_ack_i;

// Misaligned before bus error
assign writeback_exception_o =
    (dummy_ack_i &&  head_tag_i.load) ? `LSU_EXC_MISALIGNED_LOAD  :
    (dummy_ack_i && !head_tag_i.load) ? `LSU_EXC_MISALIGNED_STORE :
    (bus_fault_w &&  head_tag_i.load) ? `LSU_EXC_FAULT_LOAD       :
    (bus_fault_w && !head_tag_i.load) ? `LSU_EXC_FAULT_STORE      :
                                        `LSU_EXC_NONE;

endmodule

// ==== hw/lsu_resp_queue.sv ====
//----------------------------
// Response tag queue
// Pointer and count FIFO
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_resp_queue
#(
    // Power of two, 2 or more
    parameter int DEPTH = `LSU_QUEUE_DEPTH
)
(
     input  logic                 clk_i
    ,input  logic                 rst_i
    ,input  logic                 push_i
    ,input  lsu_pkg::lsu_tag_t    push_tag_i
    ,input  logic                 pop_i
    ,output lsu_pkg::lsu_tag_t    head_tag_o
);

localparam int ADDR_W = $clog2(DEPTH);
localparam int CNT_W  = ADDR_W + 1;

lsu_pkg::lsu_tag_t  ram_q [DEPTH-1:0];
logic [ADDR_W-1:0]  rd_ptr_q;
logic [ADDR_W-1:0]  wr_ptr_q;
logic [CNT_W-1:0]   count_q;
logic               push_ok_w;
logic               pop_ok_w;

// Full drops the push, empty drops the pop
assign push_ok_w = push_i && (count_q != CNT_W'(DEPTH));
assign pop_ok_w  = pop_i && (count_q != '0);

always_ff @(posedge clk_i)
begin
    if (rst_i)
    begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= '0;
    end
    else
    begin
        if (push_ok_w)
            wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop_ok_w)
            rd_ptr_q <= rd_ptr_q + 1'b1;
        // Simultaneous push and pop keeps the count
        case ({push_ok_w, pop_ok_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
        endcase
    end
end

// Tag storage
always_ff @(posedge clk_i)
begin
    if (push_ok_w)
        ram_q[wr_ptr_q] <= push_tag_i;
end

assign head_tag_o = ram_q[rd_ptr_q];

endmodule

// ==== hw/lsu_issue.sv ====
//----------------------------
// Request stage of the LSU
// Outstanding tracking, squash,
// dummy acknowledge and stall
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_issue
(
     input  logic                     clk_i
    ,input  logic                     rst_i
    ,input  logic [`LSU_XLEN-1:0]     addr_i
    ,input  logic                     load_i
    ,input  logic                     signed_i
    ,input  lsu_pkg::lsu_size_e       size_i
    ,input  logic                     unaligned_i
    ,input  logic                     rd_i
    ,input  logic [`LSU_STRB_W-1:0]   wr_i
    ,input  logic [`LSU_XLEN-1:0]     wr_data_i
    ,input  logic                     mem_accept_i
    ,input  logic                     mem_ack_i
    ,input  logic                     mem_error_i
    ,output logic [`LSU_XLEN-1:0]     mem_addr_o
    ,output logic [`LSU_XLEN-1:0]     mem_data_wr_o
    ,output logic                     mem_rd_o
    ,output logic [`LSU_STRB_W-1:0]   mem_wr_o
    ,output logic                     push_o
    ,output lsu_pkg::lsu_tag_t        push_tag_o
    ,output logic                     dummy_ack_o
    ,output logic                     stall_o
);

logic [`LSU_XLEN-1:0]   addr_q;
logic [`LSU_XLEN-1:0]   data_q;
logic                   rd_q;
logic [`LSU_STRB_W-1:0] wr_q;
logic                   load_q;
logic                   signed_q;
lsu_pkg::lsu_size_e     size_q;
logic                   unaligned_e1_q;
logic                   unaligned_e2_q;
logic                   pending_q;
logic                   req_q_w;
logic                   req_vis_w;
logic                   issue_w;
logic                   ack_ok_w;
logic                   ack_err_w;
logic                   delay_w;
logic                   flush_w;
logic                   advance_w;
logic                   take_w;

//----------------------------
// Outstanding access
//----------------------------
assign req_q_w   = rd_q || (|wr_q);
assign req_vis_w = mem_rd_o || (|mem_wr_o);
assign issue_w   = req_vis_w && mem_accept_i;
assign ack_ok_w  = mem_ack_i && !mem_error_i;
assign ack_err_w = mem_ack_i && mem_error_i;

// New issue wins over a completing one
always_ff @(posedge clk_i)
begin
    if (rst_i)
        pending_q <= 1'b0;
    else if (issue_w)
        pending_q <= 1'b1;
    else if (mem_ack_i)
        pending_q <= 1'b0;
end

// Older response is late
assign delay_w = pending_q && !ack_ok_w;

// Dummy ack one cycle after the misaligned stage
always_ff @(posedge clk_i)
begin
    if (rst_i)
        unaligned_e2_q <= 1'b0;
    else
        unaligned_e2_q <= unaligned_e1_q && !delay_w;
end

//----------------------------
// Stage control
//----------------------------
// Fault being reported, drop whatever is in the stage
assign flush_w   = ack_err_w || unaligned_e2_q;
assign advance_w = !flush_w && !((req_q_w || unaligned_e1_q) && delay_w) &&
                   !(req_vis_w && !mem_accept_i);
// Only a taken opcode enters the stage
assign take_w    = advance_w && !stall_o;

always_ff @(posedge clk_i)
begin
    if (rst_i || flush_w)
    begin
        rd_q           <= 1'b0;
        wr_q           <= '0;
        unaligned_e1_q <= 1'b0;
    end
    else if (advance_w)
    begin
        rd_q           <= rd_i && take_w;
        wr_q           <= wr_i & {`LSU_STRB_W{take_w}};
        unaligned_e1_q <= unaligned_i && take_w;
    end
end

// Payload follows the taken opcode
always_ff @(posedge clk_i)
begin
    if (take_w)
    begin
        addr_q   <= addr_i;
        data_q   <= wr_data_i;
        load_q   <= load_i;
        signed_q <= signed_i;
        size_q   <= size_i;
    end
end

//----------------------------
// Outputs
//----------------------------
assign mem_addr_o    = {addr_q[`LSU_XLEN-1:2], 2'b00};
assign mem_data_wr_o = data_q;
// Masked while an older ack is outstanding
assign mem_rd_o      = rd_q && !delay_w;
assign mem_wr_o      = wr_q & {`LSU_STRB_W{!delay_w}};

// Accepted request, or misaligned access leaving the stage
assign push_o        = issue_w || (unaligned_e1_q && !delay_w);

always_comb
begin
    push_tag_o.addr     = addr_q;
    push_tag_o.load     = load_q;
    push_tag_o.sign_ext = signed_q;
    push_tag_o.size     = size_q;
end

assign dummy_ack_o   = unaligned_e2_q;
assign stall_o       = (req_vis_w && !mem_accept_i) || delay_w || unaligned_e1_q;

endmodule

// ==== hw/lsu_decode.sv ====
//----------------------------
// Load/store opcode decode
// Address generation, alignment,
// store lane placement
//----------------------------
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_decode
(
     input  logic                     opcode_valid_i
    ,input  logic [`LSU_XLEN-1:0]     opcode_opcode_i
    ,input  logic [`LSU_XLEN-1:0]     opcode_ra_operand_i
    ,input  logic [`LSU_XLEN-1:0]     opcode_rb_operand_i
    ,output logic [`LSU_XLEN-1:0]     addr_o
    ,output logic                     load_o
    ,output logic                     store_o
    ,output logic                     signed_o
    ,output lsu_pkg::lsu_size_e       size_o
    ,output logic                     unaligned_o
    ,output logic                     rd_o
    ,output logic [`LSU_STRB_W-1:0]   wr_o
    ,output logic [`LSU_XLEN-1:0]     wr_data_o
);

logic [6:0]             major_w;
logic [2:0]             funct3_w;
logic                   load_w;
logic                   store_w;
logic [`LSU_XLEN-1:0]   imm_i_w;
logic [`LSU_XLEN-1:0]   imm_s_w;
logic [`LSU_XLEN-1:0]   addr_w;
lsu_pkg::lsu_size_e     size_w;
logic                   unaligned_w;

//----------------------------
// Opcode match
//----------------------------
assign major_w  = opcode_opcode_i[6:0];
assign funct3_w = opcode_opcode_i[14:12];

// Only the RV32 sizes are legal, LWU is not
assign load_w  = opcode_valid_i && (major_w == `LSU_OPC_LOAD) &&
                 ((funct3_w == `LSU_F3_B)  || (funct3_w == `LSU_F3_H) ||
                  (funct3_w == `LSU_F3_W)  || (funct3_w == `LSU_F3_BU) ||
                  (funct3_w == `LSU_F3_HU));
assign store_w = opcode_valid_i && (major_w == `LSU_OPC_STORE) &&
                 ((funct3_w == `LSU_F3_B) || (funct3_w == `LSU_F3_H) ||
                  (funct3_w == `LSU_F3_W));

//----------------------------
// Effective address
//----------------------------
// I-type for loads
assign imm_i_w = {{(`LSU_XLEN-12){opcode_opcode_i[31]}}, opcode_opcode_i[31:20]};
// S-type for stores
assign imm_s_w = {{(`LSU_XLEN-12){opcode_opcode_i[31]}}, opcode_opcode_i[31:25],
                  opcode_opcode_i[11:7]};
assign addr_w  = opcode_ra_operand_i + (store_w ? imm_s_w : imm_i_w);

// Size from the low funct3 bits
always_comb
begin
    case (funct3_w[1:0])
    2'b00:   size_w = lsu_pkg::LSU_SIZE_B;
    2'b01:   size_w = lsu_pkg::LSU_SIZE_H;
    default: size_w = lsu_pkg::LSU_SIZE_W;
    endcase
end

// Halfword on odd byte, word off a 4 byte boundary
always_comb
begin
    unaligned_w = 1'b0;
    if (load_w || store_w)
    begin
        case (size_w)
        lsu_pkg::LSU_SIZE_H: unaligned_w = addr_w[0];
        lsu_pkg::LSU_SIZE_W: unaligned_w = |addr_w[1:0];
        default:             unaligned_w = 1'b0;
        endcase
    end
end

//----------------------------
// Store lanes
//----------------------------
always_comb
begin
    wr_o      = '0;
    wr_data_o = '0;
    if (store_w && !unaligned_w)
    begin
        case (size_w)
        lsu_pkg::LSU_SIZE_B:
        begin
            // Byte copied to every lane, strobe picks one
            wr_data_o = {4{opcode_rb_operand_i[7:0]}};
            wr_o      = 4'b0001 << addr_w[1:0];
        end
        lsu_pkg::LSU_SIZE_H:
        begin
            wr_data_o = {2{opcode_rb_operand_i[15:0]}};
            wr_o      = addr_w[1] ? 4'b1100 : 4'b0011;
        end
        default:
        begin
            wr_data_o = opcode_rb_operand_i;
            wr_o      = 4'b1111;
        end
        endcase
    end
end

assign addr_o      = addr_w;
assign load_o      = load_w;
assign store_o     = store_w;
assign signed_o    = load_w && !funct3_w[2];
assign size_o      = size_w;
assign unaligned_o = unaligned_w;
// No memory read for a misaligned load
assign rd_o        = load_w && !unaligned_w;

endmodule

// ==== hw/lsu_pkg.sv ====
//----------------------------
// Load/store unit types
// Access size and response tag
//----------------------------
`include "lsu_settings.svh"

package lsu_pkg;

    //----------------------------
    // Access size
    //----------------------------
    // Matches funct3[1:0] of the access
    typedef enum logic [1:0]
    {
        LSU_SIZE_B = 2'd0,
        LSU_SIZE_H = 2'd1,
        LSU_SIZE_W = 2'd2
    } lsu_size_e;

    //----------------------------
    // Response tag
    //----------------------------
    // One per request in flight
    typedef struct packed
    {
        // Full byte address, also the fault address
        logic [`LSU_XLEN-1:0] addr;
        // Load, else store
        logic                 load;
        // Sign extend the result
        logic                 sign_ext;
        lsu_size_e            size;
    } lsu_tag_t;

endpackage

// ==== hw/lsu_settings.svh ====
//----------------------------
// Load/store unit constants
// Widths, opcode match values,
// exception codes, queue depth
//----------------------------
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath widths
`define LSU_XLEN                  32
`define LSU_STRB_W                4
`define LSU_EXC_W                 6

// Exception codes reported on writeback
`define LSU_EXC_NONE              6'd0
`define LSU_EXC_MISALIGNED_LOAD   6'd4
`define LSU_EXC_FAULT_LOAD        6'd5
`define LSU_EXC_MISALIGNED_STORE  6'd6
`define LSU_EXC_FAULT_STORE       6'd7

// Major opcodes
`define LSU_OPC_LOAD              7'b0000011
`define LSU_OPC_STORE             7'b0100011

// Funct3 access sizes
`define LSU_F3_B                  3'b000
`define LSU_F3_H                  3'b001
`define LSU_F3_W                  3'b010
`define LSU_F3_BU                 3'b100
`define LSU_F3_HU                 3'b101

// Outstanding response entries
`define LSU_QUEUE_DEPTH           2

`endif
